//--- design/dcache_pkg.sv
package dcache_pkg;

    // address split: tag | index | offset
    localparam int addr_w         = 32;
    localparam int word_w         = 32;
    localparam int words_per_line = 8;
    localparam int line_w         = words_per_line * word_w;
    localparam int num_sets       = 128;
    localparam int index_w        = 7;
    localparam int offset_w       = 5;
    localparam int tag_w          = addr_w - index_w - offset_w;

    typedef logic [addr_w-1:0]     addr_t;
    typedef logic [word_w-1:0]     word_t;
    // word 0 sits in the low bits
    typedef logic [line_w-1:0]     line_t;
    typedef logic [tag_w-1:0]      tag_t;
    typedef logic [index_w-1:0]    index_t;
    typedef logic [word_w/8-1:0]   byte_en_t;
    typedef logic                  way_t;

    typedef enum logic [2:0] {
        op_load_byte,
        op_load_half,
        op_load_word,
        op_store_byte,
        op_store_half,
        op_store_word
    } dc_op_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_store,
        st_writeback,
        st_refill,
        st_fill,
        st_respond
    } dc_state_t;

endpackage

//--- design/dcache_arrays.sv
module dcache_arrays (
    input  logic                 clk,
    input  logic                 rstn,

    input  dcache_pkg::index_t   index,
    input  dcache_pkg::tag_t     tag,

    input  logic                 wr_en,
    input  dcache_pkg::way_t     wr_way,
    input  logic [2:0]           wr_word,
    input  dcache_pkg::byte_en_t wr_byte_en,
    input  dcache_pkg::word_t    wr_data,
    input  logic                 fill_en,
    input  dcache_pkg::way_t     fill_way,
    input  dcache_pkg::line_t    fill_line,
    input  logic                 lru_touch,

    output logic                 hit,
    output dcache_pkg::way_t     hit_way,
    output dcache_pkg::line_t    rd_line,
    output dcache_pkg::way_t     victim_way,
    output logic                 victim_dirty,
    output dcache_pkg::tag_t     victim_tag,
    output dcache_pkg::line_t    victim_line
);
    import dcache_pkg::*;

    tag_t                tag_q  [2][num_sets];
    line_t               data_q [2][num_sets];
    logic [num_sets-1:0] valid_q [2];
    logic [num_sets-1:0] dirty_q [2];
    // lru bit names the least recently used way
    logic [num_sets-1:0] lru_q;
    logic [1:0]          way_hit;

    for (genvar w = 0; w < 2; w++) begin : g_cmp
        assign way_hit[w] = valid_q[w][index] && (tag_q[w][index] == tag);
    end

    assign hit     = |way_hit;
    assign hit_way = way_t'(way_hit[1]);
    assign rd_line = data_q[hit_way][index];

    // empty way wins over lru
    always_comb begin
        if (!valid_q[0][index]) begin
            victim_way = 1'b0;
        end else if (!valid_q[1][index]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_q[index];
        end
    end

    assign victim_dirty = valid_q[victim_way][index] && dirty_q[victim_way][index];
    assign victim_tag   = tag_q[victim_way][index];
    assign victim_line  = data_q[victim_way][index];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int w = 0; w < 2; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
            lru_q <= '0;
        end else begin
            if (fill_en) begin
                valid_q[fill_way][index] <= 1'b1;
                dirty_q[fill_way][index] <= 1'b0;
                lru_q[index]             <= ~fill_way;
            end
            if (wr_en) begin
                dirty_q[wr_way][index] <= 1'b1;
            end
            if (lru_touch) begin
                lru_q[index] <= ~hit_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_q[fill_way][index]  <= tag;
            data_q[fill_way][index] <= fill_line;
        end
        if (wr_en) begin
            for (int b = 0; b < word_w/8; b++) begin
                if (wr_byte_en[b]) begin
                    data_q[wr_way][index][wr_word*word_w + b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

endmodule

//--- design/dcache_mem_port.sv
module dcache_mem_port (
    input  logic              clk,
    input  logic              rstn,

    input  logic              cmd_start,
    input  logic              cmd_write,
    input  dcache_pkg::addr_t cmd_addr,
    input  dcache_pkg::line_t cmd_block,
    output logic              cmd_done,
    output dcache_pkg::line_t cmd_rblock,

    output logic              mem_req_valid,
    input  logic              mem_req_ready,
    output logic              mem_req_write,
    output dcache_pkg::addr_t mem_req_addr,
    output dcache_pkg::line_t mem_req_wblock,

    input  logic              mem_resp_valid,
    input  dcache_pkg::line_t mem_resp_rblock
);
    import dcache_pkg::*;

    logic  req_q;
    logic  wait_q;
    logic  done_q;
    logic  write_q;
    addr_t addr_q;
    line_t wblock_q;
    line_t rblock_q;
    logic  resp_fire;

    // response only counts once the request has gone out
    assign resp_fire = wait_q && !req_q && mem_resp_valid;

    assign mem_req_valid  = req_q;
    assign mem_req_write  = write_q;
    assign mem_req_addr   = addr_q;
    assign mem_req_wblock = wblock_q;
    assign cmd_done       = done_q;
    assign cmd_rblock     = rblock_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            req_q  <= 1'b0;
            wait_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (cmd_start) begin
                req_q  <= 1'b1;
                wait_q <= 1'b1;
            end else if (req_q && mem_req_ready) begin
                req_q <= 1'b0;
            end else if (resp_fire) begin
                wait_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_start) begin
            write_q  <= cmd_write;
            addr_q   <= cmd_addr;
            wblock_q <= cmd_block;
        end
        // write responses carry no data
        if (resp_fire && !write_q) begin
            rblock_q <= mem_resp_rblock;
        end
    end

endmodule

//--- design/dcache_ctrl.sv
module dcache_ctrl (
    input  logic                 clk,
    input  logic                 rstn,

    input  logic                 req_valid,
    output logic                 req_ready,
    input  dcache_pkg::dc_op_t   req_op,
    input  dcache_pkg::addr_t    req_addr,
    input  dcache_pkg::word_t    req_wdata,
    output logic                 resp_valid,
    input  logic                 resp_ready,
    output dcache_pkg::word_t    resp_rdata,

    output dcache_pkg::index_t   index,
    output dcache_pkg::tag_t     tag,
    input  logic                 hit,
    input  dcache_pkg::way_t     hit_way,
    input  dcache_pkg::line_t    rd_line,
    input  dcache_pkg::way_t     victim_way,
    input  logic                 victim_dirty,
    input  dcache_pkg::tag_t     victim_tag,
    input  dcache_pkg::line_t    victim_line,

    output logic                 wr_en,
    output dcache_pkg::way_t     wr_way,
    output logic [2:0]           wr_word,
    output dcache_pkg::byte_en_t wr_byte_en,
    output dcache_pkg::word_t    wr_data,
    output logic                 fill_en,
    output dcache_pkg::way_t     fill_way,
    output dcache_pkg::line_t    fill_line,
    output logic                 lru_touch,

    output logic                 cmd_start,
    output logic                 cmd_write,
    output dcache_pkg::addr_t    cmd_addr,
    output dcache_pkg::line_t    cmd_block,
    input  logic                 cmd_done,
    input  dcache_pkg::line_t    cmd_rblock
);
    import dcache_pkg::*;

    dc_state_t state;
    dc_state_t state_nxt;
    dc_op_t    op_q;
    addr_t     addr_q;
    word_t     wdata_q;
    word_t     load_q;
    word_t     hit_word;
    word_t     shifted;
    word_t     load_word;
    logic      is_load;

    assign index   = addr_q[offset_w +: index_w];
    assign tag     = addr_q[addr_w-1 -: tag_w];
    assign wr_word = addr_q[offset_w-1:2];
    assign is_load = (op_q == op_load_byte) || (op_q == op_load_half)
                  || (op_q == op_load_word);

    assign wr_way     = hit_way;
    assign fill_way   = victim_way;
    assign fill_line  = cmd_rblock;
    assign resp_rdata = load_q;

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            op_q    <= req_op;
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
        end
    end

    // select word, then zero-extend the addressed lane
    always_comb begin
        hit_word = rd_line[wr_word*word_w +: word_w];
        shifted  = hit_word >> {addr_q[1:0], 3'b000};
        case (op_q)
            op_load_byte: load_word = {24'b0, shifted[7:0]};
            op_load_half: load_word = {16'b0, shifted[15:0]};
            default:      load_word = shifted;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == st_lookup && hit && is_load) begin
            load_q <= load_word;
        end
    end

    // store lanes, data replicated across the word
    always_comb begin
        case (op_q)
            op_store_byte: begin
                wr_byte_en = byte_en_t'(4'b0001 << addr_q[1:0]);
                wr_data    = {4{wdata_q[7:0]}};
            end
            op_store_half: begin
                wr_byte_en = addr_q[1] ? 4'b1100 : 4'b0011;
                wr_data    = {2{wdata_q[15:0]}};
            end
            default: begin
                wr_byte_en = 4'b1111;
                wr_data    = wdata_q;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt  = state;
        req_ready  = 1'b0;
        resp_valid = 1'b0;
        wr_en      = 1'b0;
        fill_en    = 1'b0;
        lru_touch  = 1'b0;
        cmd_start  = 1'b0;
        cmd_write  = 1'b0;
        cmd_addr   = {tag, index, {offset_w{1'b0}}};
        cmd_block  = victim_line;
        case (state)
            st_idle: begin
                req_ready = 1'b1;
                if (req_valid) begin
                    state_nxt = st_lookup;
                end
            end
            st_lookup: begin
                if (hit) begin
                    lru_touch = 1'b1;
                    state_nxt = is_load ? st_respond : st_store;
                end else if (victim_dirty) begin
                    // evict first, victim address rebuilt from its tag
                    cmd_start = 1'b1;
                    cmd_write = 1'b1;
                    cmd_addr  = {victim_tag, index, {offset_w{1'b0}}};
                    state_nxt = st_writeback;
                end else begin
                    cmd_start = 1'b1;
                    state_nxt = st_refill;
                end
            end
            st_store: begin
                wr_en     = 1'b1;
                state_nxt = st_idle;
            end
            st_writeback: begin
                if (cmd_done) begin
                    cmd_start = 1'b1;
                    state_nxt = st_refill;
                end
            end
            st_refill: begin
                if (cmd_done) begin
                    state_nxt = st_fill;
                end
            end
            st_fill: begin
                fill_en   = 1'b1;
                state_nxt = st_lookup;
            end
            st_respond: begin
                resp_valid = 1'b1;
                if (resp_ready) begin
                    state_nxt = st_idle;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

endmodule

//--- design/dcache_top.sv
module dcache_top (
    input  logic               clk,
    input  logic               rstn,

    input  logic               req_valid,
    output logic               req_ready,
    input  dcache_pkg::dc_op_t req_op,
    input  dcache_pkg::addr_t  req_addr,
    input  dcache_pkg::word_t  req_wdata,

    output logic               resp_valid,
    input  logic               resp_ready,
    output dcache_pkg::word_t  resp_rdata,

    output logic               mem_req_valid,
    input  logic               mem_req_ready,
    output logic               mem_req_write,
    output dcache_pkg::addr_t  mem_req_addr,
    output dcache_pkg::line_t  mem_req_wblock,

    input  logic               mem_resp_valid,
    input  dcache_pkg::line_t  mem_resp_rblock
);
    import dcache_pkg::*;

    // controller to arrays
    index_t   index;
    tag_t     tag;
    logic     hit;
    way_t     hit_way;
    line_t    rd_line;
    way_t     victim_way;
    logic     victim_dirty;
    tag_t     victim_tag;
    line_t    victim_line;
    logic     wr_en;
    way_t     wr_way;
    logic [2:0] wr_word;
    byte_en_t wr_byte_en;
    word_t    wr_data;
    logic     fill_en;
    way_t     fill_way;
    line_t    fill_line;
    logic     lru_touch;

    // controller to memory port
    logic     cmd_start;
    logic     cmd_write;
    addr_t    cmd_addr;
    line_t    cmd_block;
    logic     cmd_done;
    line_t    cmd_rblock;

    dcache_ctrl u_ctrl (.*);

    dcache_arrays u_arrays (.*);

    dcache_mem_port u_mem_port (.*);

endmodule

//--- verif/tb_mem_model.sv
module tb_mem_model #(
    parameter int unsigned seed = 1
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              stall_en,
    input  logic              mem_req_valid,
    output logic              mem_req_ready,
    input  logic              mem_req_write,
    input  dcache_pkg::addr_t mem_req_addr,
    input  dcache_pkg::line_t mem_req_wblock,
    output logic              mem_resp_valid,
    output dcache_pkg::line_t mem_resp_rblock
);
    import dcache_pkg::*;

    // word storage keyed by byte address of the word
    word_t       words [addr_t];
    word_t       rng;
    logic        busy;
    int unsigned delay;
    line_t       pending;

    function automatic word_t step(word_t s);
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    // untouched memory reads as a hash of its word address
    function automatic word_t init_word(addr_t a);
        return step(a ^ 32'h2545_f491);
    endfunction

    function automatic line_t read_line(addr_t base);
        line_t l;
        addr_t a;
        for (int i = 0; i < words_per_line; i++) begin
            a = base + addr_t'(i * 4);
            l[i*word_w +: word_w] = words.exists(a) ? words[a] : init_word(a);
        end
        return l;
    endfunction

    initial begin
        rng             = seed;
        busy            = 1'b0;
        delay           = 0;
        pending         = '0;
        mem_req_ready   = 1'b0;
        mem_resp_valid  = 1'b0;
        mem_resp_rblock = '0;
    end

    always @(posedge clk) begin
        if (rstn && !busy && mem_req_valid && mem_req_ready) begin
            pending = '0;
            if (mem_req_write) begin
                for (int i = 0; i < words_per_line; i++) begin
                    words[mem_req_addr + addr_t'(i * 4)] = mem_req_wblock[i*word_w +: word_w];
                end
            end else begin
                pending = read_line(mem_req_addr);
            end
            rng   = step(rng);
            delay = stall_en ? 1 + rng % 6 : 1;
            busy  = 1'b1;
        end
    end

    always @(negedge clk) begin
        mem_resp_valid = 1'b0;
        if (busy) begin
            delay = delay - 1;
            if (delay == 0) begin
                mem_resp_valid  = 1'b1;
                mem_resp_rblock = pending;
                busy            = 1'b0;
            end
        end
        rng           = step(rng);
        mem_req_ready = !busy && (!stall_en || rng[1:0] != 2'b00);
    end

endmodule

//--- verif/tb_dcache.sv
module tb_dcache;
    import dcache_pkg::*;

    localparam int num_access = 330;

    logic   clk;
    logic   rstn;
    logic   req_valid;
    logic   req_ready;
    dc_op_t req_op;
    addr_t  req_addr;
    word_t  req_wdata;
    logic   resp_valid;
    logic   resp_ready;
    word_t  resp_rdata;
    logic   mem_req_valid;
    logic   mem_req_ready;
    logic   mem_req_write;
    addr_t  mem_req_addr;
    line_t  mem_req_wblock;
    logic   mem_resp_valid;
    line_t  mem_resp_rblock;
    logic   stall_en;

    word_t  rng_state;
    word_t  exp_q [$];
    logic   log_write [$];
    addr_t  log_addr [$];
    line_t  log_block [$];
    logic [7:0] ref_mem [addr_t];

    dcache_top DUT (.*);

    tb_mem_model #(.seed(3007)) u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t xorshift(word_t s);
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    function word_t next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic word_t init_word(addr_t a);
        return xorshift(a ^ 32'h2545_f491);
    endfunction

    function automatic logic [7:0] ref_byte(addr_t a);
        word_t w;
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        w = init_word({a[31:2], 2'b00});
        return w[a[1:0]*8 +: 8];
    endfunction

    // expected load result with zero extension
    function automatic word_t ref_load(dc_op_t op, addr_t a);
        case (op)
            op_load_byte: return {24'b0, ref_byte(a)};
            op_load_half: return {16'b0, ref_byte(a + 1), ref_byte(a)};
            default:      return {ref_byte(a + 3), ref_byte(a + 2), ref_byte(a + 1), ref_byte(a)};
        endcase
    endfunction

    task automatic ref_store(dc_op_t op, addr_t a, word_t d);
        int n;
        n = (op == op_store_byte) ? 1 : (op == op_store_half) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            ref_mem[a + addr_t'(i)] = d[i*8 +: 8];
        end
    endtask

    function automatic line_t ref_line(addr_t base);
        line_t l;
        for (int i = 0; i < 32; i++) begin
            l[i*8 +: 8] = ref_byte(base + addr_t'(i));
        end
        return l;
    endfunction

    function automatic addr_t mk_addr(tag_t t, index_t i, logic [4:0] off);
        return {t, i, off};
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_addr(addr_t got, addr_t exp, string what);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic access(dc_op_t op, addr_t a, word_t d);
        @(negedge clk);
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = a;
        req_wdata = d;
        if (op inside {op_load_byte, op_load_half, op_load_word}) begin
            exp_q.push_back(ref_load(op, a));
        end else begin
            ref_store(op, a, d);
        end
        do @(posedge clk); while (!req_ready);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        do @(negedge clk); while (!(req_ready && exp_q.size() == 0));
    endtask

    task automatic expect_requests(int n);
        if (log_addr.size() != n) begin
            abort_run($sformatf("expected %0d memory requests but saw %0d", n, log_addr.size()));
        end
    endtask

    task automatic clear_log();
        log_write.delete();
        log_addr.delete();
        log_block.delete();
    endtask

    always @(posedge clk) begin
        if (mem_req_valid && mem_req_ready) begin
            log_write.push_back(mem_req_write);
            log_addr.push_back(mem_req_addr);
            log_block.push_back(mem_req_wblock);
        end
    end

    // responses in order against the queue
    always @(posedge clk) begin
        if (rstn && resp_valid && resp_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("load response arrived with no load outstanding");
            end else begin
                check_word(resp_rdata, exp_q.pop_front(), "load data");
            end
        end
    end

    always @(negedge clk) begin
        resp_ready = stall_en ? (next_rand() % 4 != 0) : 1'b1;
    end

    initial begin
        repeat (num_access * 400) @(posedge clk);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        addr_t a;
        addr_t evict;
        line_t blk;
        word_t r;
        dc_op_t op;
        rng_state  = 32'd3007;
        stall_en   = 1'b0;
        rstn       = 1'b0;
        req_valid  = 1'b0;
        req_op     = op_load_word;
        req_addr   = '0;
        req_wdata  = '0;
        resp_ready = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        // cold miss
        a = 32'h0001_2344;
        access(op_load_word, a, '0);
        wait_idle();
        expect_requests(1);
        if (log_write[0] !== 1'b0) begin
            abort_run("cold miss sent a write request instead of a read");
        end
        check_addr(log_addr[0], 32'h0001_2340, "refill address");
        clear_log();

        // mixed-width stores merged into one word
        a = 32'h0001_2348;
        access(op_store_word, a, 32'h1122_3344);
        access(op_store_byte, a + 1, 32'h0000_00ab);
        access(op_store_half, a + 2, 32'h0000_beef);
        access(op_load_byte, a + 1, '0);
        access(op_load_half, a + 2, '0);
        access(op_load_word, a, '0);
        access(op_load_byte, a + 3, '0);
        access(op_load_half, a, '0);
        wait_idle();
        clear_log();

        // dirty eviction with the first tag as lru
        access(op_store_word, mk_addr(20'h00100, 7'h10, 5'h04), 32'hcafe_0001);
        access(op_store_word, mk_addr(20'h00200, 7'h10, 5'h08), 32'hcafe_0002);
        wait_idle();
        clear_log();
        evict = mk_addr(20'h00100, 7'h10, 5'h00);
        access(op_load_word, mk_addr(20'h00300, 7'h10, 5'h00), '0);
        wait_idle();
        expect_requests(2);
        if (log_write[0] !== 1'b1 || log_write[1] !== 1'b0) begin
            abort_run("write-back and refill came in the wrong order");
        end
        check_addr(log_addr[0], evict, "write-back address");
        blk = ref_line(evict);
        for (int i = 0; i < words_per_line; i++) begin
            check_word(log_block[0][i*word_w +: word_w], blk[i*word_w +: word_w],
                       "write-back data");
        end
        check_addr(log_addr[1], mk_addr(20'h00300, 7'h10, 5'h00), "refill address");
        access(op_load_word, mk_addr(20'h00100, 7'h10, 5'h04), '0);
        wait_idle();
        clear_log();

        // A, B, A, C evicts B
        access(op_load_word, mk_addr(20'h00a00, 7'h20, 5'h00), '0);
        access(op_load_word, mk_addr(20'h00b00, 7'h20, 5'h00), '0);
        access(op_load_word, mk_addr(20'h00a00, 7'h20, 5'h04), '0);
        wait_idle();
        clear_log();
        access(op_load_word, mk_addr(20'h00c00, 7'h20, 5'h00), '0);
        wait_idle();
        expect_requests(1);
        check_addr(log_addr[0], mk_addr(20'h00c00, 7'h20, 5'h00), "refill address");
        clear_log();
        access(op_load_word, mk_addr(20'h00a00, 7'h20, 5'h08), '0);
        wait_idle();
        expect_requests(0);

        // random traffic with stalls
        @(posedge clk);
        stall_en = 1'b1;
        for (int n = 0; n < 300; n++) begin
            // rising edge keeps these draws apart from the resp_ready draws
            @(posedge clk);
            r  = next_rand();
            op = dc_op_t'(3'(r % 6));
            a  = mk_addr(tag_t'(1 + r[3:2]), index_t'(r[5:4]), r[20:16]);
            if (op == op_load_half || op == op_store_half) begin
                a[0] = 1'b0;
            end else if (op == op_load_word || op == op_store_word) begin
                a[1:0] = 2'b00;
            end
            access(op, a, next_rand());
        end
        wait_idle();
        stall_en = 1'b0;

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- build.f
design/dcache_pkg.sv
design/dcache_arrays.sv
design/dcache_mem_port.sv
design/dcache_ctrl.sv
design/dcache_top.sv
verif/tb_mem_model.sv
verif/tb_dcache.sv

//--- Makefile
SRCS := $(wildcard design/*.sv verif/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_dcache: build.f $(SRCS)
	verilator --binary --timing --top-module tb_dcache -f build.f -o Vtb_dcache

run: obj_dir/Vtb_dcache
	./obj_dir/Vtb_dcache | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
